// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ns
TOP       = vec_diff_tb
FILELIST  = vec_diff.f
OBJ_DIR   = obj_dir
PASS_MSG  = Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass or fail comes from the simulation output itself
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== source/vec_diff_top.sv ====
`timescale 1ns/1ns

module vec_diff_top (
    input  logic            clock,
    input  logic            reset,
    input  logic            in_wr_en,
    input  vec_pkg::vec_t   in_x,
    input  vec_pkg::vec_t   in_y,
    output logic            in_full,
    input  logic            out_rd_en,
    output vec_pkg::vec_t   out_diff,
    output vec_pkg::norm2_t out_norm2,
    output logic            out_empty
);

    import vec_pkg::*;

    vec_pair_t   in_din;
    vec_pair_t   in_dout;
    logic        in_empty;
    logic        in_rd_en;

    vec_t        mid_din;
    logic        mid_wr_en;
    logic        mid_full;
    vec_t        mid_dout;
    logic        mid_empty;
    logic        mid_rd_en;

    vec_t        res_diff;
    norm2_t      res_norm2;
    vec_result_t res_din;
    vec_result_t res_dout;
    logic        res_wr_en;
    logic        res_full;

    assign in_din.x = in_x;
    assign in_din.y = in_y;

    assign res_din.diff  = res_diff;
    assign res_din.norm2 = res_norm2;

    assign out_diff  = res_dout.diff;
    assign out_norm2 = res_dout.norm2;

    //////////////////////////////////////////////////////////////////////
    // input side
    //////////////////////////////////////////////////////////////////////

    vec_fifo #(
        .payload_t (vec_pair_t),
        .DEPTH     (FIFO_DEPTH)
    ) i_in_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (in_wr_en),
        .din   (in_din),
        .full  (in_full),
        .rd_en (in_rd_en),
        .dout  (in_dout),
        .empty (in_empty)
    );

    //////////////////////////////////////////////////////////////////////
    // processing
    //////////////////////////////////////////////////////////////////////

    vec_sub_stage i_sub (
        .clock     (clock),
        .reset     (reset),
        .x         (in_dout.x),
        .y         (in_dout.y),
        .in_empty  (in_empty),
        .in_rd_en  (in_rd_en),
        .out       (mid_din),
        .out_full  (mid_full),
        .out_wr_en (mid_wr_en)
    );

    vec_fifo #(
        .payload_t (vec_t),
        .DEPTH     (FIFO_DEPTH)
    ) i_mid_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (mid_wr_en),
        .din   (mid_din),
        .full  (mid_full),
        .rd_en (mid_rd_en),
        .dout  (mid_dout),
        .empty (mid_empty)
    );

    vec_norm2_stage i_norm2 (
        .clock     (clock),
        .reset     (reset),
        .diff      (mid_dout),
        .in_empty  (mid_empty),
        .in_rd_en  (mid_rd_en),
        .out_diff  (res_diff),
        .out_norm2 (res_norm2),
        .out_full  (res_full),
        .out_wr_en (res_wr_en)
    );

    //////////////////////////////////////////////////////////////////////
    // output side
    //////////////////////////////////////////////////////////////////////

    vec_fifo #(
        .payload_t (vec_result_t),
        .DEPTH     (FIFO_DEPTH)
    ) i_out_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (res_wr_en),
        .din   (res_din),
        .full  (res_full),
        .rd_en (out_rd_en),
        .dout  (res_dout),
        .empty (out_empty)
    );

endmodule

// ==== source/vec_fifo.sv ====
`timescale 1ns/1ns

module vec_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 16
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     wr_en,
    input  payload_t din,
    output logic     full,
    input  logic     rd_en,
    output payload_t dout,
    output logic     empty
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t        mem [DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [AW:0]     count;
    logic            do_wr;
    logic            do_rd;

    // a write while full or a read while empty is dropped.
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    assign full  = (count == (AW+1)'(DEPTH));
    assign empty = (count == '0);

    // first word falls through.
    assign dout = mem[rd_ptr];

    //////////////////////////////////////////////////////////////////////
    // pointers and occupancy
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // both at once keeps the count.
            case ({do_wr, do_rd})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

endmodule

// ==== source/vec_norm2_stage.sv ====
`timescale 1ns/1ns

module vec_norm2_stage (
    input  logic            clock,
    input  logic            reset,
    input  vec_pkg::vec_t   diff,
    input  logic            in_empty,
    output logic            in_rd_en,
    output vec_pkg::vec_t   out_diff,
    output vec_pkg::norm2_t out_norm2,
    input  logic            out_full,
    output logic            out_wr_en
);

    import vec_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        SUM,
        WRITE
    } state_t;

    state_t state;
    state_t next_state;
    norm2_t sq_q [VEC_LEN];

    //////////////////////////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        in_rd_en   = 1'b0;
        out_wr_en  = 1'b0;

        case (state)
            IDLE: begin
                if (!in_empty) begin
                    in_rd_en   = 1'b1;
                    next_state = SUM;
                end
            end

            // the add always takes exactly one cycle.
            SUM: begin
                next_state = WRITE;
            end

            WRITE: begin
                if (!out_full) begin
                    out_wr_en  = 1'b1;
                    next_state = IDLE;
                end
            end

            default: begin
                next_state = IDLE;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // datapath
    //////////////////////////////////////////////////////////////////////

    // multiply on the pop edge, add on the next one.
    always_ff @(posedge clock) begin
        if (in_rd_en) begin
            out_diff <= diff;
            for (int i = 0; i < VEC_LEN; i++) begin
                sq_q[i] <= norm2_t'($signed(diff[i])) * norm2_t'($signed(diff[i]));
            end
        end
        if (state == SUM) begin
            out_norm2 <= sq_q[0] + sq_q[1] + sq_q[2];
        end
    end

endmodule

// ==== source/vec_pkg.sv ====
package vec_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths and sizes
    //////////////////////////////////////////////////////////////////////

    // bits in one vector component.
    localparam int COORD_W = 32;

    // bits in the squared length.
    localparam int NORM2_W = 64;

    // components per vector.
    localparam int VEC_LEN = 3;

    // depth of every queue in the chain, a power of two.
    localparam int FIFO_DEPTH = 16;

    //////////////////////////////////////////////////////////////////////
    // payload types
    //////////////////////////////////////////////////////////////////////

    // one signed component.
    typedef logic signed [COORD_W-1:0] coord_t;

    // three components, index 0 in the low bits.
    typedef coord_t [VEC_LEN-1:0] vec_t;

    // squared length, wraps at 64 bits.
    typedef logic signed [NORM2_W-1:0] norm2_t;

    // input queue entry.
    typedef struct packed {
        vec_t x;
        vec_t y;
    } vec_pair_t;

    // output queue entry.
    typedef struct packed {
        vec_t   diff;
        norm2_t norm2;
    } vec_result_t;

endpackage

// ==== source/vec_sub_stage.sv ====
`timescale 1ns/1ns

module vec_sub_stage (
    input  logic          clock,
    input  logic          reset,
    input  vec_pkg::vec_t x,
    input  vec_pkg::vec_t y,
    input  logic          in_empty,
    output logic          in_rd_en,
    output vec_pkg::vec_t out,
    input  logic          out_full,
    output logic          out_wr_en
);

    import vec_pkg::*;

    typedef enum logic {
        IDLE,
        WRITE
    } state_t;

    state_t state;
    state_t next_state;
    vec_t   out_c;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= IDLE;
            out   <= '0;
        end else begin
            state <= next_state;
            out   <= out_c;
        end
    end

    // pop one pair, hold the difference until the middle queue takes it.
    always_comb begin
        out_c      = out;
        next_state = state;
        in_rd_en   = 1'b0;
        out_wr_en  = 1'b0;

        case (state)
            IDLE: begin
                if (!in_empty) begin
                    // wraps at 32 bits.
                    for (int i = 0; i < VEC_LEN; i++) begin
                        out_c[i] = x[i] - y[i];
                    end
                    in_rd_en   = 1'b1;
                    next_state = WRITE;
                end
            end

            WRITE: begin
                if (!out_full) begin
                    out_wr_en  = 1'b1;
                    next_state = IDLE;
                end
            end

            default: begin
                next_state = IDLE;
            end
        endcase
    end

endmodule

// ==== vec_diff.f ====
source/vec_pkg.sv
source/vec_fifo.sv
source/vec_sub_stage.sv
source/vec_norm2_stage.sv
source/vec_diff_top.sv
verification/vec_diff_tb.sv

// ==== verification/vec_diff_tb.sv ====
`timescale 1ns/1ns

module vec_diff_tb;

    import vec_pkg::*;

    logic        clock;
    logic        reset;
    logic        in_wr_en;
    vec_t        in_x;
    vec_t        in_y;
    logic        in_full;
    logic        out_rd_en;
    vec_t        out_diff;
    norm2_t      out_norm2;
    logic        out_empty;

    integer      seed;
    int          errors;
    int          test_base;
    int          tests_passed;
    int          tests_failed;
    int          accepted;
    vec_result_t exp_q [$];

    vec_diff_top i_dut (
        .clock     (clock),
        .reset     (reset),
        .in_wr_en  (in_wr_en),
        .in_x      (in_x),
        .in_y      (in_y),
        .in_full   (in_full),
        .out_rd_en (out_rd_en),
        .out_diff  (out_diff),
        .out_norm2 (out_norm2),
        .out_empty (out_empty)
    );

    always #2 clock = ~clock;

    //////////////////////////////////////////////////////////////////////
    // reference model and scoreboard
    //////////////////////////////////////////////////////////////////////

    // difference wraps at 32 bits, squares are sign extended and wrap at 64.
    function automatic vec_result_t model(input vec_t x, input vec_t y);
        vec_result_t r;
        coord_t      c;
        longint      d;
        r.norm2 = '0;
        for (int i = 0; i < VEC_LEN; i++) begin
            c = x[i] - y[i];
            d = c;
            r.diff[i] = c;
            r.norm2 = r.norm2 + d * d;
        end
        return r;
    endfunction

    task automatic rand_vec(output vec_t v);
        for (int i = 0; i < VEC_LEN; i++) begin
            v[i] = $random(seed);
        end
    endtask

    task automatic check_output();
        vec_result_t want;
        if (exp_q.size() == 0) begin
            $display("at %0t the DUT gave a result that was never written", $time);
            errors++;
        end else begin
            want = exp_q.pop_front();
            if (out_diff !== want.diff) begin
                $display("** Error at %0t: diff expected %h, got %h", $time, want.diff, out_diff);
                errors++;
            end
            if (out_norm2 !== want.norm2) begin
                $display("** Error at %0t: norm2 expected %h, got %h",
                         $time, want.norm2, out_norm2);
                errors++;
            end
        end
    endtask

    // one cycle, called just after a falling edge.
    task automatic step(input logic wr, input vec_t x, input vec_t y, input logic rd);
        in_wr_en  = wr;
        in_x      = x;
        in_y      = y;
        out_rd_en = rd;
        if (wr && !in_full) begin
            exp_q.push_back(model(x, y));
            accepted++;
        end
        if (rd && !out_empty) begin
            check_output();
        end
        @(negedge clock);
    endtask

    task automatic drain(input string what);
        int cyc;
        cyc = 0;
        while (exp_q.size() != 0 && cyc < 1000) begin
            step(1'b0, '0, '0, 1'b1);
            cyc++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout in %s: %0d results never came out", what, exp_q.size());
            errors++;
        end
        // anything popped from here on is an extra item.
        repeat (8) step(1'b0, '0, '0, 1'b1);
        if (out_empty !== 1'b1) begin
            $display("** Error at %0t: out_empty expected 1 after %s", $time, what);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        if (errors == test_base) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: FAIL (%0d errors)", name, errors - test_base);
        end
        test_base = errors;
    endtask

    //////////////////////////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////////////////////////

    initial begin
        vec_t        x;
        vec_t        y;
        logic [31:0] r;
        logic [1:0]  a;
        logic [1:0]  b;
        int          cyc;
        int          held;
        int          base;
        coord_t      extremes [4];

        seed         = 32'hef82_a034;
        errors       = 0;
        test_base    = 0;
        tests_passed = 0;
        tests_failed = 0;
        accepted     = 0;
        clock        = 1'b0;
        reset        = 1'b1;
        in_wr_en     = 1'b0;
        in_x         = '0;
        in_y         = '0;
        out_rd_en    = 1'b0;
        extremes[0]  = 32'h7fff_ffff;
        extremes[1]  = 32'h8000_0000;
        extremes[2]  = 32'h0000_0000;
        extremes[3]  = 32'hffff_ffff;

        repeat (4) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);

        if (out_empty !== 1'b1 || in_full !== 1'b0) begin
            $display("** Error at %0t: after reset out_empty=%b in_full=%b",
                     $time, out_empty, in_full);
            errors++;
        end
        end_test("reset state");

        rand_vec(x);
        rand_vec(y);
        step(1'b1, x, y, 1'b0);
        cyc = 0;
        while (out_empty && cyc < 100) begin
            step(1'b0, '0, '0, 1'b0);
            cyc++;
        end
        if (out_empty) begin
            $display("timeout waiting for the single result to reach the output");
            errors++;
        end
        step(1'b0, '0, '0, 1'b1);
        if (out_empty !== 1'b1 || exp_q.size() != 0) begin
            $display("** Error at %0t: output not empty after the single pop", $time);
            errors++;
        end
        end_test("single item");

        base = accepted;
        cyc  = 0;
        while (accepted - base < 200 && cyc < 3000) begin
            rand_vec(x);
            rand_vec(y);
            step(1'b1, x, y, 1'b1);
            cyc++;
        end
        if (accepted - base < 200) begin
            $display("timeout: only %0d of 200 pairs were accepted", accepted - base);
            errors++;
        end
        drain("streaming");
        end_test("streaming");

        // the output queue fills first, then both stages stall, then the rest.
        // in_full only stays high once every stage has stalled.
        cyc  = 0;
        held = 0;
        while (held < 8 && cyc < 500) begin
            rand_vec(x);
            rand_vec(y);
            step(1'b1, x, y, 1'b0);
            if (in_full) begin
                held++;
            end else begin
                held = 0;
            end
            cyc++;
        end
        if (held < 8) begin
            $display("timeout waiting for in_full to stay high with the output held");
            errors++;
        end
        if (exp_q.size() != 3 * FIFO_DEPTH + 2) begin
            $display("** Error at %0t: %0d items held, expected %0d",
                     $time, exp_q.size(), 3 * FIFO_DEPTH + 2);
            errors++;
        end
        drain("back-pressure");
        end_test("back-pressure");

        for (int k = 0; k < 16; k++) begin
            a    = k[1:0];
            b    = k[3:2];
            x[0] = extremes[a];
            x[1] = extremes[b];
            x[2] = extremes[a + b];
            y[0] = extremes[b];
            y[1] = extremes[a ^ b];
            y[2] = extremes[a - b];
            base = accepted;
            cyc  = 0;
            while (accepted == base && cyc < 100) begin
                step(1'b1, x, y, 1'b1);
                cyc++;
            end
            if (accepted == base) begin
                $display("timeout: extreme pair %0d was never accepted", k);
                errors++;
            end
        end
        drain("wrap-around");
        end_test("wrap-around");

        base = accepted;
        cyc  = 0;
        while (accepted - base < 300 && cyc < 6000) begin
            rand_vec(x);
            rand_vec(y);
            r = $random(seed);
            step(r[0], x, y, r[1]);
            cyc++;
        end
        if (accepted - base < 300) begin
            $display("timeout: only %0d of 300 random pairs were accepted", accepted - base);
            errors++;
        end
        drain("random flow");
        end_test("random flow");

        $display("tests passed: %0d, tests with errors: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
